//--- verilog/eth_tx_pkg.sv
/*
 * Shared definitions for the MII transmit framer.
 * Holds the sequencer state encoding, the tag carried with each nibble
 * from the sequencer to the CRC stage, and the Ethernet framing constants.
 * Other files refer to these by scoped name.
 */

package eth_tx_pkg;

    // ========================================================================
    // encodings
    // ========================================================================

    // transmit sequencer states
    typedef enum logic [2:0] {
        IDLE,
        PREA,
        SFD,
        TX_LO,
        TX_HI,
        FCS,
        GAP
    } tx_state_e;

    // what the nibble on the sequencer to CRC link is
    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_PREAMBLE,
        KIND_DATA,
        KIND_FCS
    } nibble_kind_e;

    // ========================================================================
    // framing constants
    // ========================================================================

    localparam logic [3:0]  PREAMBLE_NIBBLE    = 4'h5;
    localparam logic [3:0]  SFD_NIBBLE         = 4'hD;
    localparam int          PREAMBLE_COUNT     = 15;
    localparam int          FCS_NIBBLES        = 8;
    localparam int          IFG_CYCLES         = 24;

    // IEEE 802.3 CRC-32, bit reversed for lsb-first shifting
    localparam logic [31:0] CRC_POLY_REFLECTED = 32'hEDB8_8320;
    localparam logic [31:0] CRC_INIT           = 32'hFFFF_FFFF;

endpackage

//--- verilog/eth_tx_buffer.sv
/*
 * Frame byte buffer.
 * The host writes one byte per cycle through wr_en_i, the sequencer
 * reads through a registered port, so rd_data_o shows the byte at
 * rd_addr_i one cycle after the address is presented.
 */

module eth_tx_buffer
#(
    parameter int ADDR_W = 11
)
(
    input  logic              mtx_clk_i,

    // host write port
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  logic [7:0]        wr_data_i,

    // sequencer read port
    input  logic [ADDR_W-1:0] rd_addr_i,
    output logic [7:0]        rd_data_o
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [7:0] mem [0:DEPTH-1];

    // write side
    always_ff @(posedge mtx_clk_i)
    begin
        if (wr_en_i)
        begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // read side, one cycle of latency
    always_ff @(posedge mtx_clk_i)
    begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- verilog/eth_tx_sequencer.sv
/*
 * Transmit sequencer, the middle stage of the framer.
 * A start strobe latches the frame length, then the FSM walks through
 * preamble, SFD, the data bytes (low nibble first), eight FCS slots and
 * the inter-frame gap. Each cycle it hands one tagged nibble to the CRC
 * stage. FCS slots are only marked here, their value comes from the CRC.
 */

module eth_tx_sequencer
#(
    parameter int ADDR_W = 11
)
(
    input  logic                     mtx_clk_i,
    input  logic                     reset_i,

    // frame start from the host
    input  logic                     start_i,
    input  logic [ADDR_W:0]          len_i,

    // buffer read port
    output logic [ADDR_W-1:0]        rd_addr_o,
    input  logic [7:0]               rd_data_i,

    // tagged nibble to the CRC stage
    output logic [3:0]               nib_o,
    output eth_tx_pkg::nibble_kind_e kind_o,

    output logic                     busy_o
);

    // the count register also times the gap, so it needs at least 5 bits
    localparam int CNT_W = (ADDR_W + 1 > 8) ? ADDR_W + 1 : 8;

    eth_tx_pkg::tx_state_e state_r;
    logic [CNT_W-1:0]      count_r;
    logic [ADDR_W:0]       len_r;
    logic [ADDR_W-1:0]     rd_addr_r;
    logic [CNT_W-1:0]      last_byte;

    assign last_byte = CNT_W'(len_r) - 1'b1;

    // length is only looked at while a frame is in flight
    always_ff @(posedge mtx_clk_i)
    begin
        if (state_r == eth_tx_pkg::IDLE && start_i)
        begin
            len_r <= len_i;
        end
    end

    // ========================================================================
    // state machine
    // ========================================================================

    always_ff @(posedge mtx_clk_i)
    begin
        if (reset_i)
        begin
            state_r   <= eth_tx_pkg::IDLE;
            count_r   <= '0;
            rd_addr_r <= '0;
        end
        else
        begin
            case (state_r)
                eth_tx_pkg::IDLE:
                begin
                    count_r <= '0;
                    if (start_i)
                    begin
                        state_r   <= eth_tx_pkg::PREA;
                        // byte 0 is fetched while the preamble goes out
                        rd_addr_r <= '0;
                    end
                end

                eth_tx_pkg::PREA:
                begin
                    if (count_r == CNT_W'(eth_tx_pkg::PREAMBLE_COUNT - 1))
                    begin
                        state_r <= eth_tx_pkg::SFD;
                        count_r <= '0;
                    end
                    else
                    begin
                        count_r <= count_r + 1'b1;
                    end
                end

                eth_tx_pkg::SFD:
                begin
                    state_r <= eth_tx_pkg::TX_LO;
                end

                // step the address here: the registered read then lands
                // on the next byte exactly when TX_HI hands over to TX_LO
                eth_tx_pkg::TX_LO:
                begin
                    state_r   <= eth_tx_pkg::TX_HI;
                    rd_addr_r <= rd_addr_r + 1'b1;
                end

                eth_tx_pkg::TX_HI:
                begin
                    if (count_r == last_byte)
                    begin
                        state_r <= eth_tx_pkg::FCS;
                        count_r <= '0;
                    end
                    else
                    begin
                        state_r <= eth_tx_pkg::TX_LO;
                        count_r <= count_r + 1'b1;
                    end
                end

                eth_tx_pkg::FCS:
                begin
                    if (count_r == CNT_W'(eth_tx_pkg::FCS_NIBBLES - 1))
                    begin
                        state_r <= eth_tx_pkg::GAP;
                        count_r <= '0;
                    end
                    else
                    begin
                        count_r <= count_r + 1'b1;
                    end
                end

                eth_tx_pkg::GAP:
                begin
                    if (count_r == CNT_W'(eth_tx_pkg::IFG_CYCLES - 1))
                    begin
                        state_r <= eth_tx_pkg::IDLE;
                        count_r <= '0;
                    end
                    else
                    begin
                        count_r <= count_r + 1'b1;
                    end
                end

                default:
                begin
                    state_r <= eth_tx_pkg::IDLE;
                    count_r <= '0;
                end
            endcase
        end
    end

    // ========================================================================
    // nibble and tag for the CRC stage
    // ========================================================================

    always_comb
    begin
        nib_o  = 4'h0;
        kind_o = eth_tx_pkg::KIND_NONE;
        case (state_r)
            eth_tx_pkg::PREA:
            begin
                nib_o  = eth_tx_pkg::PREAMBLE_NIBBLE;
                kind_o = eth_tx_pkg::KIND_PREAMBLE;
            end
            // SFD shares the preamble tag, the CRC stays in reset through it
            eth_tx_pkg::SFD:
            begin
                nib_o  = eth_tx_pkg::SFD_NIBBLE;
                kind_o = eth_tx_pkg::KIND_PREAMBLE;
            end
            eth_tx_pkg::TX_LO:
            begin
                nib_o  = rd_data_i[3:0];
                kind_o = eth_tx_pkg::KIND_DATA;
            end
            eth_tx_pkg::TX_HI:
            begin
                nib_o  = rd_data_i[7:4];
                kind_o = eth_tx_pkg::KIND_DATA;
            end
            eth_tx_pkg::FCS:
            begin
                kind_o = eth_tx_pkg::KIND_FCS;
            end
            default:
            begin
                kind_o = eth_tx_pkg::KIND_NONE;
            end
        endcase
    end

    assign rd_addr_o = rd_addr_r;
    assign busy_o    = (state_r != eth_tx_pkg::IDLE);

endmodule

//--- verilog/eth_tx_crc.sv
/*
 * CRC and output stage, last of the three pipeline stages.
 * Runs a reflected CRC-32 over the DATA nibbles, restarts it on any
 * preamble nibble and, in the FCS slots, drives the complemented CRC
 * out four bits at a time. mtxd_o and mtxdv_o are registered here,
 * one cycle behind the sequencer.
 */

module eth_tx_crc
(
    input  logic                     mtx_clk_i,
    input  logic                     reset_i,

    // tagged nibble from the sequencer
    input  logic [3:0]               nib_i,
    input  eth_tx_pkg::nibble_kind_e kind_i,

    // MII transmit side
    output logic [3:0]               mtxd_o,
    output logic                     mtxdv_o
);

    logic [31:0] crc_r;

    // four steps of the lsb-first shift register, bit 0 of the nibble first
    function automatic logic [31:0] crc_nibble(input logic [31:0] crc,
                                               input logic [3:0]  d);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 4; i++)
        begin
            fb = c[0] ^ d[i];
            c  = c >> 1;
            if (fb)
            begin
                c = c ^ eth_tx_pkg::CRC_POLY_REFLECTED;
            end
        end
        return c;
    endfunction

    // ========================================================================
    // running CRC
    // ========================================================================

    always_ff @(posedge mtx_clk_i)
    begin
        case (kind_i)
            eth_tx_pkg::KIND_PREAMBLE: crc_r <= eth_tx_pkg::CRC_INIT;
            eth_tx_pkg::KIND_DATA:     crc_r <= crc_nibble(crc_r, nib_i);
            // low nibble has just gone out, bring the next one down
            eth_tx_pkg::KIND_FCS:      crc_r <= crc_r >> 4;
            default:                   crc_r <= crc_r;
        endcase
    end

    // ========================================================================
    // MII output registers
    // ========================================================================

    always_ff @(posedge mtx_clk_i)
    begin
        if (reset_i)
        begin
            mtxd_o  <= 4'h0;
            mtxdv_o <= 1'b0;
        end
        else
        begin
            mtxdv_o <= (kind_i != eth_tx_pkg::KIND_NONE);
            case (kind_i)
                eth_tx_pkg::KIND_FCS:  mtxd_o <= ~crc_r[3:0];
                eth_tx_pkg::KIND_NONE: mtxd_o <= 4'h0;
                default:               mtxd_o <= nib_i;
            endcase
        end
    end

endmodule

//--- verilog/eth_tx_top.sv
/*
 * Top level of the MII transmit framer.
 * Load the frame through the byte write port, then pulse start_i with
 * the byte count on len_i. The frame leaves on mtxd_o/mtxdv_o with
 * preamble, SFD and FCS added; busy_o covers the frame and the gap.
 */

module eth_tx_top
#(
    parameter int ADDR_W = 11
)
(
    input  logic              mtx_clk_i,
    input  logic              reset_i,

    // frame buffer load
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  logic [7:0]        wr_data_i,

    // frame start
    input  logic              start_i,
    input  logic [ADDR_W:0]   len_i,

    // MII transmit
    output logic [3:0]        mtxd_o,
    output logic              mtxdv_o,
    output logic              busy_o
);

    logic [ADDR_W-1:0]        rd_addr;
    logic [7:0]               rd_data;
    logic [3:0]               nib;
    eth_tx_pkg::nibble_kind_e kind;

    // ========================================================================
    // stage 1: byte buffer
    // ========================================================================

    eth_tx_buffer #(
        .ADDR_W    (ADDR_W)
    ) eth_tx_buffer_i (
        .mtx_clk_i (mtx_clk_i),
        .wr_en_i   (wr_en_i),
        .wr_addr_i (wr_addr_i),
        .wr_data_i (wr_data_i),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    // ========================================================================
    // stage 2: sequencer
    // ========================================================================

    eth_tx_sequencer #(
        .ADDR_W    (ADDR_W)
    ) eth_tx_sequencer_i (
        .mtx_clk_i (mtx_clk_i),
        .reset_i   (reset_i),
        .start_i   (start_i),
        .len_i     (len_i),
        .rd_addr_o (rd_addr),
        .rd_data_i (rd_data),
        .nib_o     (nib),
        .kind_o    (kind),
        .busy_o    (busy_o)
    );

    // ========================================================================
    // stage 3: CRC and MII outputs
    // ========================================================================

    eth_tx_crc eth_tx_crc_i (
        .mtx_clk_i (mtx_clk_i),
        .reset_i   (reset_i),
        .nib_i     (nib),
        .kind_i    (kind),
        .mtxd_o    (mtxd_o),
        .mtxdv_o   (mtxdv_o)
    );

endmodule

//--- test/tb_clock_gen.sv
/*
 * Testbench clock and reset source.
 * Free-running clock of PERIOD time units, reset held high for
 * RESET_CYCLES rising edges and released shortly after the last one.
 */

module tb_clock_gen
#(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
)
(
    output logic clk_o,
    output logic reset_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial
    begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10;
        reset_o = 1'b0;
    end

endmodule

//--- test/eth_tx_tb.sv
/*
 * Directed testbench for the MII transmit framer.
 * Each test loads the frame buffer, pulses start_i and collects the
 * nibbles while mtxdv_o is high, then compares them against a frame
 * built here from preamble, SFD, data and a bytewise CRC-32 model.
 * Run through the Makefile; the first error ends the run.
 */

module eth_tx_tb;

    localparam int          ADDR_W      = 11;
    localparam int          LEN_W       = ADDR_W + 1;
    localparam int          PRE_NIBBLES = 15;
    localparam int          IFG_MIN     = 24;
    localparam logic [31:0] POLY        = 32'hEDB8_8320;

    logic              mtx_clk;
    logic              reset;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [7:0]        wr_data;
    logic              start;
    logic [LEN_W-1:0]  len;
    logic [3:0]        mtxd;
    logic              mtxdv;
    logic              busy;

    logic [7:0]        frame_bytes[$];
    logic [3:0]        expected_nibs[$];
    logic [3:0]        got_nibs[$];

    int                cycle_count = 0;
    int                cycle_limit = 200;
    int                low_run     = 0;
    int                last_gap    = 0;

    tb_clock_gen #(
        .PERIOD       (100),
        .RESET_CYCLES (4)
    ) tb_clock_gen_i (
        .clk_o        (mtx_clk),
        .reset_o      (reset)
    );

    eth_tx_top #(
        .ADDR_W    (ADDR_W)
    ) eth_tx_top_i (
        .mtx_clk_i (mtx_clk),
        .reset_i   (reset),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .start_i   (start),
        .len_i     (len),
        .mtxd_o    (mtxd),
        .mtxdv_o   (mtxdv),
        .busy_o    (busy)
    );

    // ========================================================================
    // run limit and gap monitor
    // ========================================================================

    always @(posedge mtx_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    // length of the last idle stretch of mtxdv_o before a frame
    always @(negedge mtx_clk)
    begin
        if (mtxdv)
        begin
            if (low_run != 0)
            begin
                last_gap <= low_run;
            end
            low_run <= 0;
        end
        else
        begin
            low_run <= low_run + 1;
        end
    end

    // ========================================================================
    // helpers
    // ========================================================================

    task automatic value_error(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    // load plus transmit plus gap, with margin
    task automatic add_budget(input int n);
        cycle_limit += 3 * n + 100;
    endtask

    // IEEE CRC-32 over frame_bytes, final value already complemented
    function automatic logic [31:0] crc32_of_bytes();
        logic [31:0] crc;
        crc = 32'hFFFF_FFFF;
        foreach (frame_bytes[i])
        begin
            crc = crc ^ {24'h0, frame_bytes[i]};
            for (int b = 0; b < 8; b++)
            begin
                crc = crc[0] ? ((crc >> 1) ^ POLY) : (crc >> 1);
            end
        end
        return ~crc;
    endfunction

    task automatic build_expected();
        logic [31:0] fcs;
        fcs = crc32_of_bytes();
        expected_nibs.delete();
        repeat (PRE_NIBBLES) expected_nibs.push_back(4'h5);
        expected_nibs.push_back(4'hD);
        foreach (frame_bytes[i])
        begin
            expected_nibs.push_back(frame_bytes[i][3:0]);
            expected_nibs.push_back(frame_bytes[i][7:4]);
        end
        for (int k = 0; k < 8; k++)
        begin
            expected_nibs.push_back(fcs[4*k +: 4]);
        end
    endtask

    task automatic load_buffer();
        foreach (frame_bytes[i])
        begin
            @(posedge mtx_clk);
            #10;
            wr_en   = 1'b1;
            wr_addr = ADDR_W'(i);
            wr_data = frame_bytes[i];
        end
        @(posedge mtx_clk);
        #10;
        wr_en = 1'b0;
    endtask

    // hold off until the previous frame and its gap are over
    task automatic wait_idle();
        while (busy === 1'b1)
        begin
            @(negedge mtx_clk);
        end
    endtask

    task automatic pulse_start(input int n);
        @(posedge mtx_clk);
        #10;
        start = 1'b1;
        len   = LEN_W'(n);
        @(posedge mtx_clk);
        #10;
        start = 1'b0;
    endtask

    // called right after pulse_start, samples at the falling edge
    task automatic collect_frame();
        got_nibs.delete();
        @(negedge mtx_clk);
        assert (busy === 1'b1) else value_error("busy_o is not high the cycle after start");
        assert (mtxdv === 1'b0) else value_error("mtxdv_o rose one cycle too early");
        @(negedge mtx_clk);
        assert (mtxdv === 1'b1) else value_error("no preamble two cycles after start");
        while (mtxdv === 1'b1)
        begin
            got_nibs.push_back(mtxd);
            @(negedge mtx_clk);
        end
    endtask

    task automatic check_frame(input string name);
        build_expected();
        assert (got_nibs.size() == expected_nibs.size())
        else value_error($sformatf("%s: %0d nibbles sent, expected %0d",
                                   name, got_nibs.size(), expected_nibs.size()));
        foreach (expected_nibs[i])
        begin
            assert (got_nibs[i] === expected_nibs[i])
            else value_error($sformatf("%s: nibble %0d is %h, expected %h",
                                       name, i, got_nibs[i], expected_nibs[i]));
        end
    endtask

    // ========================================================================
    // tests
    // ========================================================================

    // known check value of the standard CRC-32
    task automatic check_crc_model();
        frame_bytes.delete();
        for (int i = 0; i < 9; i++)
        begin
            frame_bytes.push_back(8'h31 + 8'(i));
        end
        assert (crc32_of_bytes() == 32'hCBF4_3926)
        else value_error("CRC model gives the wrong check value for 123456789");
    endtask

    task automatic test_reset_idle();
        repeat (20)
        begin
            @(negedge mtx_clk);
            assert (mtxdv === 1'b0 && busy === 1'b0 && mtxd === 4'h0)
            else value_error($sformatf("idle outputs dv=%b busy=%b d=%h", mtxdv, busy, mtxd));
        end
    endtask

    task automatic test_header_frame();
        logic [7:0] header [0:13];
        header = '{8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF,
                   8'h00, 8'h11, 8'h22, 8'h33, 8'h44, 8'h55,
                   8'h08, 8'h00};
        frame_bytes.delete();
        foreach (header[i])
        begin
            frame_bytes.push_back(header[i]);
        end
        add_budget(14);
        load_buffer();
        wait_idle();
        pulse_start(14);
        collect_frame();
        check_frame("header frame");
    endtask

    task automatic test_random_frame();
        int n;
        n = 1 + int'($urandom % 200);
        frame_bytes.delete();
        repeat (n) frame_bytes.push_back(8'($urandom));
        add_budget(n);
        load_buffer();
        wait_idle();
        pulse_start(n);
        collect_frame();
        check_frame($sformatf("random frame of %0d bytes", n));
    endtask

    task automatic test_busy_start_ignored();
        frame_bytes.delete();
        for (int i = 0; i < 20; i++)
        begin
            frame_bytes.push_back(8'(8'hA0 + i));
        end
        add_budget(20);
        load_buffer();
        wait_idle();
        pulse_start(20);
        fork
            collect_frame();
            begin
                // one stray start in the preamble, one in the data
                repeat (5) @(posedge mtx_clk);
                pulse_start(5);
                repeat (25) @(posedge mtx_clk);
                pulse_start(5);
            end
        join
        check_frame("frame with stray starts");
        // and one more in the gap
        repeat (4) @(negedge mtx_clk);
        assert (busy === 1'b1) else value_error("busy_o dropped before the gap ended");
        pulse_start(5);
        repeat (40)
        begin
            @(negedge mtx_clk);
            assert (mtxdv === 1'b0) else value_error("a start during busy began a frame");
        end
        assert (busy === 1'b0) else value_error("busy_o still high long after the frame");
    endtask

    task automatic test_back_to_back();
        frame_bytes.delete();
        for (int i = 0; i < 30; i++)
        begin
            frame_bytes.push_back(8'(i * 7 + 3));
        end
        add_budget(30);
        load_buffer();
        wait_idle();
        pulse_start(30);
        collect_frame();
        check_frame("first of two frames");
        // rewrite the buffer while the gap runs
        frame_bytes.delete();
        for (int i = 0; i < 17; i++)
        begin
            frame_bytes.push_back(8'(8'hF0 ^ (i * 13)));
        end
        add_budget(17);
        load_buffer();
        wait_idle();
        pulse_start(17);
        collect_frame();
        check_frame("second of two frames");
        assert (last_gap >= IFG_MIN)
        else value_error($sformatf("only %0d idle cycles between frames", last_gap));
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================

    initial
    begin
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = 8'h00;
        start   = 1'b0;
        len     = '0;
        void'($urandom(17730));

        wait (reset === 1'b0);
        check_crc_model();
        test_reset_idle();
        test_header_frame();
        test_random_frame();
        test_busy_start_ignored();
        test_back_to_back();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- eth_tx.f
verilog/eth_tx_pkg.sv
verilog/eth_tx_buffer.sv
verilog/eth_tx_sequencer.sv
verilog/eth_tx_crc.sv
verilog/eth_tx_top.sv
test/tb_clock_gen.sv
test/eth_tx_tb.sv

//--- Makefile
# Verilator simulation of the MII transmit framer

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= eth_tx_tb
FILELIST  ?= eth_tx.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# build and run; a $fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
